// File: hw/core_mem_cfg_pkg.sv
`default_nettype none

package core_mem_cfg_pkg;

	localparam int CMEM_ADDR_W = 13;
	localparam int LANE_W = 8;
	localparam int BANK_NUM = 16;
	localparam int CMEM_DATA_W = BANK_NUM * LANE_W; // one row holds a byte per bank lane.
	localparam int USER_W = 2;

	localparam int LANE_SEL_W = $clog2(BANK_NUM);
	localparam int WROW_W = CMEM_ADDR_W - 1;
	localparam int CROW_W = CMEM_ADDR_W - 1 - LANE_SEL_W;

	// weight view of the compute address.
	typedef struct packed {
		logic              sel; // zero selects the weight array.
		logic [WROW_W-1:0] row;
	} wmem_addr_t;

	// cache view of the compute address.
	typedef struct packed {
		logic                  sel; // one selects the key/value cache.
		logic [LANE_SEL_W-1:0] lane;
		logic [CROW_W-1:0]     row;
	} kv_addr_t;

	typedef union packed {
		wmem_addr_t w;
		kv_addr_t   kv;
	} cmem_addr_u;

endpackage

`default_nettype wire

// File: hw/core_mem_port_pkg.sv
`default_nettype none

package core_mem_port_pkg;

	import core_mem_cfg_pkg::*;

	localparam logic TGT_WMEM = 1'b0;
	localparam logic TGT_KV = 1'b1;

	// one access toward a single-port array.
	typedef struct packed {
		logic                   wen;
		logic                   ren;
		logic [WROW_W-1:0]      addr;
		logic [CMEM_DATA_W-1:0] wdata;
		logic [CMEM_DATA_W-1:0] bwe; // bit enable, a set bit lets the write through.
	} mem_req_t;

	// one byte access toward the key/value cache.
	typedef struct packed {
		logic                  wen;
		logic                  ren;
		logic [LANE_SEL_W-1:0] lane;
		logic [CROW_W-1:0]     row;
		logic [LANE_W-1:0]     wbyte;
	} kv_req_t;

	typedef struct packed {
		logic valid;
		logic target; // TGT_WMEM or TGT_KV.
	} rd_tag_t;

endpackage

`default_nettype wire

// File: hw/sram_sp.sv
`timescale 1ns/10ps
`default_nettype none

module sram_sp import core_mem_port_pkg::*; #(
	parameter int DEPTH = 1024,
	parameter int DATA_W = 128
) (
	input  wire              clk,
	input  wire mem_req_t    req,
	output logic [DATA_W-1:0] rdata
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [DATA_W-1:0] mem [DEPTH];
	logic [AW-1:0]     row;
	logic [DATA_W-1:0] bwe;
	logic [DATA_W-1:0] wdata;

	assign row = req.addr[AW-1:0];
	assign bwe = req.bwe[DATA_W-1:0];
	assign wdata = req.wdata[DATA_W-1:0];

	always_ff @(posedge clk) begin
		if (req.wen) begin
			mem[row] <= (mem[row] & ~bwe) | (wdata & bwe); // only enabled bits change.
		end
		if (req.ren) begin
			rdata <= mem[row]; // read data holds until the next read.
		end
	end

endmodule

`default_nettype wire

// File: hw/cmem_decode.sv
`timescale 1ns/10ps
`default_nettype none

module cmem_decode import core_mem_cfg_pkg::*, core_mem_port_pkg::*; #(
	parameter int WMEM_DEPTH = 1024
) (
	input  wire                   clk,
	input  wire                   rstn,
	input  wire cmem_addr_u       cmem_addr,
	input  wire                   cmem_wen,
	input  wire [CMEM_DATA_W-1:0] cmem_wdata,
	input  wire                   cmem_ren,
	output mem_req_t              wmem_req,
	output kv_req_t               kv_req,
	output rd_tag_t               rd_tag
);

	logic                   is_kv;
	logic                   w_wen_q;
	logic                   w_ren_q;
	logic                   kv_wen_q;
	logic                   kv_ren_q;
	rd_tag_t                tag_q;
	cmem_addr_u             addr_q;
	logic [CMEM_DATA_W-1:0] wdata_q;

	assign is_kv = cmem_addr.kv.sel;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			w_wen_q <= 1'b0;
			w_ren_q <= 1'b0;
			kv_wen_q <= 1'b0;
			kv_ren_q <= 1'b0;
			tag_q <= '0;
		end else begin
			w_wen_q <= cmem_wen && !is_kv;
			w_ren_q <= cmem_ren && !is_kv;
			kv_wen_q <= cmem_wen && is_kv;
			kv_ren_q <= cmem_ren && is_kv;
			tag_q.valid <= cmem_ren;
			tag_q.target <= is_kv ? TGT_KV : TGT_WMEM;
		end
	end

	always_ff @(posedge clk) begin
		if (cmem_wen || cmem_ren) begin
			addr_q <= cmem_addr;
		end
		if (cmem_wen) begin
			wdata_q <= cmem_wdata;
		end
	end

	assign wmem_req.wen = w_wen_q;
	assign wmem_req.ren = w_ren_q;
	assign wmem_req.addr = addr_q.w.row;
	assign wmem_req.wdata = wdata_q;
	assign wmem_req.bwe = {CMEM_DATA_W{w_wen_q}}; // weight writes always cover the whole row.

	assign kv_req.wen = kv_wen_q;
	assign kv_req.ren = kv_ren_q;
	assign kv_req.lane = addr_q.kv.lane;
	assign kv_req.row = addr_q.kv.row;
	assign kv_req.wbyte = wdata_q[LANE_W-1:0]; // the cache stores only the low byte.

	assign rd_tag = tag_q;

	a_no_wr_rd: assert property (@(posedge clk) disable iff (!rstn)
		!(cmem_wen && cmem_ren))
		else $error("compute write and read issued in the same cycle");

	a_wrow_range: assert property (@(posedge clk) disable iff (!rstn)
		(cmem_wen || cmem_ren) && !cmem_addr.w.sel |-> cmem_addr.w.row < WMEM_DEPTH)
		else $error("weight row %0d is outside the array", cmem_addr.w.row);

endmodule

`default_nettype wire

// File: hw/kv_cache.sv
`timescale 1ns/10ps
`default_nettype none

module kv_cache import core_mem_cfg_pkg::*, core_mem_port_pkg::*; #(
	parameter int CACHE_DEPTH = 128,
	parameter int NUM_USERS = 4
) (
	input  wire                    clk,
	input  wire                    rstn,
	input  wire kv_req_t           kv_req,
	input  wire [USER_W-1:0]       active_user,
	input  wire                    clean_kv_cache,
	input  wire [USER_W-1:0]       clean_user,
	output logic [CMEM_DATA_W-1:0] rdata,
	output logic                   clean_busy,
	output logic                   clean_done
);

	localparam int ROW_IDX_W = (CACHE_DEPTH > 1) ? $clog2(CACHE_DEPTH) : 1;
	localparam int ARR_DEPTH = NUM_USERS * CACHE_DEPTH;
	localparam int ARR_ROW_W = $clog2(ARR_DEPTH);

	logic [ROW_IDX_W-1:0]   clean_cnt;
	logic [USER_W-1:0]      clean_user_q;
	logic                   clean_last;
	logic [ARR_ROW_W-1:0]   acc_row;
	logic [ARR_ROW_W-1:0]   clean_row;
	logic [CMEM_DATA_W-1:0] lane_bwe;
	mem_req_t               arr_req;

	// each user owns CACHE_DEPTH consecutive rows of the shared array.
	function automatic logic [ARR_ROW_W-1:0] user_row(
		input logic [USER_W-1:0]    user,
		input logic [ROW_IDX_W-1:0] row
	);
		return ARR_ROW_W'(user) * ARR_ROW_W'(CACHE_DEPTH) + ARR_ROW_W'(row);
	endfunction

	assign acc_row = user_row(active_user, kv_req.row[ROW_IDX_W-1:0]);
	assign clean_row = user_row(clean_user_q, clean_cnt);
	assign clean_last = (clean_cnt == ROW_IDX_W'(CACHE_DEPTH - 1));

	always_comb begin
		for (int i = 0; i < BANK_NUM; i++) begin
			lane_bwe[i*LANE_W +: LANE_W] = {LANE_W{kv_req.wen && (kv_req.lane == LANE_SEL_W'(i))}};
		end
	end

	always_comb begin
		if (clean_busy) begin
			arr_req.wen = 1'b1; // the sequencer owns the array port while busy.
			arr_req.ren = 1'b0;
			arr_req.addr = WROW_W'(clean_row);
			arr_req.wdata = '0;
			arr_req.bwe = '1;
		end else begin
			arr_req.wen = kv_req.wen;
			arr_req.ren = kv_req.ren;
			arr_req.addr = WROW_W'(acc_row);
			arr_req.wdata = {BANK_NUM{kv_req.wbyte}}; // lane_bwe picks the one lane that lands.
			arr_req.bwe = lane_bwe;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			clean_busy <= 1'b0;
			clean_done <= 1'b0;
			clean_cnt <= '0;
			clean_user_q <= '0;
		end else begin
			clean_done <= clean_busy && clean_last;
			if (clean_busy) begin
				clean_cnt <= clean_cnt + 1'b1;
				if (clean_last) begin
					clean_busy <= 1'b0;
				end
			end else if (clean_kv_cache) begin
				clean_busy <= 1'b1;
				clean_cnt <= '0;
				clean_user_q <= clean_user;
			end
		end
	end

	sram_sp #(
		.DEPTH (ARR_DEPTH),
		.DATA_W(CMEM_DATA_W)
	) u_cache_arr (
		.clk  (clk),
		.req  (arr_req),
		.rdata(rdata)
	);

	a_no_access_busy: assert property (@(posedge clk) disable iff (!rstn)
		clean_busy |-> !(kv_req.wen || kv_req.ren))
		else $error("cache access arrived while a clean is running");

	a_clean_done: assert property (@(posedge clk) disable iff (!rstn)
		$rose(clean_busy) |-> ##CACHE_DEPTH clean_done)
		else $error("clean_done did not follow the last cleared row");

endmodule

`default_nettype wire

// File: hw/rdata_select.sv
`timescale 1ns/10ps
`default_nettype none

module rdata_select import core_mem_cfg_pkg::*, core_mem_port_pkg::*; (
	input  wire                    clk,
	input  wire                    rstn,
	input  wire rd_tag_t           rd_tag,
	input  wire [CMEM_DATA_W-1:0]  wmem_rdata,
	input  wire [CMEM_DATA_W-1:0]  kv_rdata,
	output logic [CMEM_DATA_W-1:0] cmem_rdata,
	output logic                   cmem_rvalid
);

	rd_tag_t tag_q; // lines up with the registered array output.

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			tag_q <= '0;
		end else begin
			tag_q <= rd_tag;
		end
	end

	always_comb begin
		cmem_rvalid = tag_q.valid;
		if (!tag_q.valid) begin
			cmem_rdata = '0;
		end else if (tag_q.target == TGT_KV) begin
			cmem_rdata = kv_rdata;
		end else begin
			cmem_rdata = wmem_rdata;
		end
	end

endmodule

`default_nettype wire

// File: hw/core_mem.sv
`timescale 1ns/10ps
`default_nettype none

module core_mem import core_mem_cfg_pkg::*, core_mem_port_pkg::*; #(
	parameter int WMEM_DEPTH = 1024,
	parameter int CACHE_DEPTH = 128,
	parameter int NUM_USERS = 4
) (
	input  wire                    clk,
	input  wire                    rstn,
	input  wire cmem_addr_u        cmem_addr,
	input  wire                    cmem_wen,
	input  wire [CMEM_DATA_W-1:0]  cmem_wdata,
	input  wire                    cmem_ren,
	input  wire [USER_W-1:0]       active_user,
	input  wire                    clean_kv_cache,
	input  wire [USER_W-1:0]       clean_user,
	output logic [CMEM_DATA_W-1:0] cmem_rdata,
	output logic                   cmem_rvalid,
	output logic                   clean_busy,
	output logic                   clean_done
);

	mem_req_t               wmem_req;
	kv_req_t                kv_req;
	rd_tag_t                rd_tag;
	logic [CMEM_DATA_W-1:0] wmem_rdata;
	logic [CMEM_DATA_W-1:0] kv_rdata;

	cmem_decode #(
		.WMEM_DEPTH(WMEM_DEPTH)
	) u_decode (
		.clk       (clk),
		.rstn      (rstn),
		.cmem_addr (cmem_addr),
		.cmem_wen  (cmem_wen),
		.cmem_wdata(cmem_wdata),
		.cmem_ren  (cmem_ren),
		.wmem_req  (wmem_req),
		.kv_req    (kv_req),
		.rd_tag    (rd_tag)
	);

	sram_sp #(
		.DEPTH (WMEM_DEPTH),
		.DATA_W(CMEM_DATA_W)
	) u_wmem (
		.clk  (clk),
		.req  (wmem_req),
		.rdata(wmem_rdata)
	);

	kv_cache #(
		.CACHE_DEPTH(CACHE_DEPTH),
		.NUM_USERS  (NUM_USERS)
	) u_kv_cache (
		.clk           (clk),
		.rstn          (rstn),
		.kv_req        (kv_req),
		.active_user   (active_user),
		.clean_kv_cache(clean_kv_cache),
		.clean_user    (clean_user),
		.rdata         (kv_rdata),
		.clean_busy    (clean_busy),
		.clean_done    (clean_done)
	);

	rdata_select u_rdata_select (
		.clk        (clk),
		.rstn       (rstn),
		.rd_tag     (rd_tag),
		.wmem_rdata (wmem_rdata),
		.kv_rdata   (kv_rdata),
		.cmem_rdata (cmem_rdata),
		.cmem_rvalid(cmem_rvalid)
	);

endmodule

`default_nettype wire

// File: dv/core_mem_ref.svh
`ifndef CORE_MEM_REF_SVH
`define CORE_MEM_REF_SVH

// shadow copies of both arrays, updated when each access is issued.
logic [CMEM_DATA_W-1:0] wmem_shadow [WMEM_DEPTH];
logic [CMEM_DATA_W-1:0] kv_shadow [NUM_USERS*CACHE_DEPTH];
logic [31:0]            lfsr_state = 32'h316f_4a5d;

// x^32 + x^22 + x^2 + x + 1, the new bit enters at the bottom.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [CMEM_DATA_W-1:0] rand_bits(input int n);
	logic [CMEM_DATA_W-1:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state); // one step per bit taken.
		v = {v[CMEM_DATA_W-2:0], lfsr_state[0]};
	end
	return v;
endfunction

// each user owns a slice of CACHE_DEPTH rows, higher cache row bits are dropped.
function automatic int kv_index(input int user, input int row);
	return user * CACHE_DEPTH + (row % CACHE_DEPTH);
endfunction

function automatic void shadow_write(input cmem_addr_u a, input logic [CMEM_DATA_W-1:0] d,
	input int user);
	int idx;
	if (!a.w.sel) begin
		wmem_shadow[int'(a.w.row)] = d; // weight writes replace the whole row.
	end else begin
		idx = kv_index(user, int'(a.kv.row));
		kv_shadow[idx][int'(a.kv.lane)*LANE_W +: LANE_W] = d[LANE_W-1:0];
	end
endfunction

function automatic void shadow_clean(input int user);
	for (int r = 0; r < CACHE_DEPTH; r++) begin
		kv_shadow[kv_index(user, r)] = '0;
	end
endfunction

// expected row returned for a read of address a under the given active user.
function automatic logic [CMEM_DATA_W-1:0] ref_read(input cmem_addr_u a, input int user);
	if (!a.w.sel) begin
		return wmem_shadow[int'(a.w.row)];
	end
	return kv_shadow[kv_index(user, int'(a.kv.row))];
endfunction

`endif

// File: dv/core_mem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module core_mem_tb import core_mem_cfg_pkg::*; ();

	localparam int WMEM_DEPTH = 1024;
	localparam int CACHE_DEPTH = 128;
	localparam int NUM_USERS = 4;
	localparam int RD_TIMEOUT = 20;
	localparam int CLEAN_TIMEOUT = CACHE_DEPTH + 16;

	logic                   clk = 1'b0;
	logic                   rstn;
	cmem_addr_u             cmem_addr;
	logic                   cmem_wen;
	logic [CMEM_DATA_W-1:0] cmem_wdata;
	logic                   cmem_ren;
	logic [USER_W-1:0]      active_user;
	logic                   clean_kv_cache;
	logic [USER_W-1:0]      clean_user;
	logic [CMEM_DATA_W-1:0] cmem_rdata;
	logic                   cmem_rvalid;
	logic                   clean_busy;
	logic                   clean_done;
	int                     err_cnt = 0;
	int                     chk_cnt = 0;
	int                     cycle_cnt = 0;
	int                     test_base = 0;
	logic [CMEM_DATA_W-1:0] exp_q [$];
	int                     issue_q [$];

	`include "core_mem_ref.svh"

	core_mem #(
		.WMEM_DEPTH (WMEM_DEPTH),
		.CACHE_DEPTH(CACHE_DEPTH),
		.NUM_USERS  (NUM_USERS)
	) dut_i (.*);

	always #5 clk = ~clk;

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	function automatic void check_value(input string name, input logic [CMEM_DATA_W-1:0] got,
		input logic [CMEM_DATA_W-1:0] exp);
		chk_cnt++;
		assert (got === exp) else begin
			$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
			err_cnt++;
		end
	endfunction

	function automatic cmem_addr_u wmem_addr(input int row);
		cmem_addr_u a;
		a.w.sel = 1'b0;
		a.w.row = WROW_W'(row);
		return a;
	endfunction

	function automatic cmem_addr_u kv_addr(input int lane, input int row);
		cmem_addr_u a;
		a.kv.sel = 1'b1;
		a.kv.lane = LANE_SEL_W'(lane);
		a.kv.row = CROW_W'(row);
		return a;
	endfunction

	function automatic void report_test(input int n, input string name);
		$display("test %0d %s: %0d errors", n, name, err_cnt - test_base);
		test_base = err_cnt;
	endfunction

	task automatic abort_run(input string why);
		$display("error at %0t: %s", $time, why);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic go_idle();
		@(negedge clk);
		cmem_wen = 1'b0;
		cmem_ren = 1'b0;
		clean_kv_cache = 1'b0;
	endtask

	task automatic issue_write(input cmem_addr_u a, input logic [CMEM_DATA_W-1:0] d);
		@(negedge clk);
		cmem_addr = a;
		cmem_wdata = d;
		cmem_wen = 1'b1;
		cmem_ren = 1'b0;
		shadow_write(a, d, int'(active_user));
	endtask

	task automatic issue_read(input cmem_addr_u a);
		@(negedge clk);
		cmem_addr = a;
		cmem_wen = 1'b0;
		cmem_ren = 1'b1;
		exp_q.push_back(ref_read(a, int'(active_user)));
		issue_q.push_back(cycle_cnt);
	endtask

	// the cache applies active_user one edge after decode, so earlier accesses drain first.
	task automatic switch_user(input int u);
		go_idle();
		go_idle();
		active_user = USER_W'(u);
	endtask

	task automatic wait_reads_done();
		int t;
		go_idle();
		t = 0;
		while (exp_q.size() != 0 && t < RD_TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (exp_q.size() != 0) abort_run("read data did not return before the timeout");
	endtask

	task automatic run_clean(input int u);
		int t;
		go_idle();
		@(negedge clk);
		clean_user = USER_W'(u);
		clean_kv_cache = 1'b1;
		@(negedge clk);
		clean_kv_cache = 1'b0;
		check_value("clean_busy", clean_busy, 1);
		t = 0; // edges counted after the one that took the pulse.
		while (!clean_done && t < CLEAN_TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (!clean_done) abort_run("clean_done did not pulse after a clean");
		check_value("clean_done latency", t, CACHE_DEPTH); // the last row clears on that edge.
		check_value("clean_busy", clean_busy, 0);
		@(negedge clk);
		check_value("clean_done", clean_done, 0); // a single pulse only.
		shadow_clean(u);
	endtask

	always @(negedge clk) begin
		logic [CMEM_DATA_W-1:0] exp_data;
		int issued;
		if (!cmem_rvalid) begin
			check_value("cmem_rdata", cmem_rdata, '0);
		end else begin
			chk_cnt++;
			assert (exp_q.size() != 0) else begin
				$display("error at %0t: cmem_rvalid high with no read outstanding", $time);
				err_cnt++;
			end
			if (exp_q.size() != 0) begin
				exp_data = exp_q.pop_front();
				issued = issue_q.pop_front();
				check_value("cmem_rdata", cmem_rdata, exp_data);
				check_value("read latency", cycle_cnt - issued, 2);
			end
		end
	end

	initial begin
		int wrows [16];
		int kvrows [4];
		int row;
		int row3;
		int user3;
		int cu;
		rstn = 1'b0;
		cmem_addr = '0;
		cmem_wen = 1'b0;
		cmem_wdata = '0;
		cmem_ren = 1'b0;
		active_user = '0;
		clean_kv_cache = 1'b0;
		clean_user = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		check_value("cmem_rvalid", cmem_rvalid, 0);
		check_value("clean_busy", clean_busy, 0);
		check_value("clean_done", clean_done, 0);
		check_value("cmem_rdata", cmem_rdata, '0);
		rstn = 1'b1;
		for (int u = 0; u < NUM_USERS; u++) run_clean(u); // gives the cache a known state.
		report_test(1, "reset state and cache clear");

		for (int i = 0; i < 16; i++) begin
			wrows[i] = int'(rand_bits(10));
			issue_write(wmem_addr(wrows[i]), rand_bits(CMEM_DATA_W));
		end
		for (int i = 0; i < 16; i++) issue_read(wmem_addr(wrows[i]));
		wait_reads_done();
		report_test(2, "weight write and read back");

		user3 = int'(rand_bits(USER_W));
		row3 = int'(rand_bits(CROW_W));
		switch_user(user3);
		for (int l = 0; l < BANK_NUM; l++) begin
			issue_write(kv_addr(l, row3), rand_bits(CMEM_DATA_W));
		end
		for (int i = 0; i < 6; i++) begin
			issue_write(kv_addr(int'(rand_bits(LANE_SEL_W)), row3), rand_bits(CMEM_DATA_W));
		end
		issue_read(kv_addr(0, row3));
		wait_reads_done();
		report_test(3, "cache lane merge");

		row = int'(rand_bits(CROW_W));
		for (int u = 0; u < NUM_USERS; u++) begin
			switch_user(u);
			for (int l = 0; l < BANK_NUM; l++) begin
				issue_write(kv_addr(l, row), rand_bits(CMEM_DATA_W));
			end
		end
		for (int u = 0; u < NUM_USERS; u++) begin
			switch_user(u);
			issue_read(kv_addr(0, row));
		end
		switch_user(0);
		issue_read(kv_addr(0, row));
		wait_reads_done();
		report_test(4, "user row isolation");

		cu = int'(rand_bits(USER_W));
		run_clean(cu);
		for (int u = 0; u < NUM_USERS; u++) begin
			switch_user(u);
			issue_read(kv_addr(0, row));
		end
		switch_user(user3);
		issue_read(kv_addr(0, row3));
		switch_user(cu);
		for (int i = 0; i < 4; i++) issue_read(kv_addr(0, int'(rand_bits(CROW_W))));
		wait_reads_done();
		report_test(5, "clean of one user");

		switch_user(int'(rand_bits(USER_W)));
		for (int i = 0; i < 4; i++) begin
			kvrows[i] = int'(rand_bits(CROW_W));
			issue_write(kv_addr(int'(rand_bits(LANE_SEL_W)), kvrows[i]), rand_bits(CMEM_DATA_W));
		end
		for (int i = 0; i < 8; i++) begin
			issue_read(wmem_addr(wrows[i]));
			issue_read(kv_addr(0, kvrows[i % 4]));
		end
		wait_reads_done();
		report_test(6, "alternating back-to-back reads");

		$display("tests 6, checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: core_mem.f
+incdir+dv
hw/core_mem_cfg_pkg.sv
hw/core_mem_port_pkg.sv
hw/sram_sp.sv
hw/cmem_decode.sv
hw/kv_cache.sv
hw/rdata_select.sv
hw/core_mem.sv
dv/core_mem_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module core_mem_tb -f core_mem.f -o core_mem_sim

./obj_dir/core_mem_sim | tee sim.log

if grep -qx "TB PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
